/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// ************************************************
	// Widths
	// ************************************************
	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [3:0]  strb_t;
	typedef logic [2:0]  axi_size_t;
	typedef logic [1:0]  resp_t;

	// RISC-V load/store width codes.
	localparam funct3_t F3_B  = 3'd0;
	localparam funct3_t F3_H  = 3'd1;
	localparam funct3_t F3_W  = 3'd2;
	localparam funct3_t F3_BU = 3'd4;
	localparam funct3_t F3_HU = 3'd5;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam int unsigned MEM_BYTES  = 1024;
	localparam int unsigned MEM_WORDS  = 256;
	localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);

	// ************************************************
	// Request, write-back and bus channel payloads
	// ************************************************
	typedef struct packed {
		word_t    exu_val;    // Address, or value for register-only ops.
		word_t    store_data;
		funct3_t  funct3;
		reg_idx_t rd;
		logic     ren;
		logic     wen;
		logic     reg_wen;
	} lsu_req_t;

	typedef struct packed {
		word_t    val;
		reg_idx_t rd;
		logic     reg_wen;
		logic     err;        // Bus returned a non-OKAY response.
	} wb_t;

	typedef struct packed {
		word_t     addr;
		axi_size_t size;
	} axi_addr_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} axi_w_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} axi_r_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE,
		WRITE_RESP,
		DONE
	} lsu_state_e;

endpackage

`default_nettype wire

/* store_align.sv */
`timescale 1ns/1ns
`default_nettype none

module store_align import lsu_pkg::*; (
	input  funct3_t    funct3,
	input  wire [1:0]  offset,
	input  word_t      store_data,
	output axi_w_t     w_data
);

	strb_t base_mask;

	// Byte count from the width bits; signedness does not matter for stores.
	always_comb begin
		case (funct3[1:0])
			F3_B[1:0]: base_mask = 4'b0001;
			F3_H[1:0]: base_mask = 4'b0011;
			F3_W[1:0]: base_mask = 4'b1111;
			default:   base_mask = 4'b0000;
		endcase
	end

	assign w_data.strb = base_mask << offset;
	assign w_data.data = store_data << {offset, 3'b000};    // Move into byte lane.

endmodule

`default_nettype wire

/* load_extend.sv */
`timescale 1ns/1ns
`default_nettype none

module load_extend import lsu_pkg::*; (
	input  funct3_t    funct3,
	input  wire [1:0]  offset,
	input  word_t      rdata,
	output word_t      load_val
);

	word_t shifted;

	assign shifted = rdata >> {offset, 3'b000};    // Addressed byte to bit 0.

	always_comb begin
		case (funct3)
			F3_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
			F3_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
			F3_W:    load_val = shifted;
			F3_BU:   load_val = {24'd0, shifted[7:0]};
			F3_HU:   load_val = {16'd0, shifted[15:0]};
			default: load_val = '0;    // Not a load code.
		endcase
	end

endmodule

`default_nettype wire

/* data_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_sram import lsu_pkg::*; (
	input  wire        clock,
	input  wire        rst_n,

	input  axi_addr_t  ar,
	input  wire        arvalid,
	output logic       arready,
	output axi_r_t     r,
	output logic       rvalid,

	input  axi_addr_t  aw,
	input  wire        awvalid,
	output logic       awready,
	input  axi_w_t     w,
	input  wire        wvalid,
	output logic       wready,
	output resp_t      bresp,
	output logic       bvalid
);

	typedef enum logic {
		S_IDLE,
		S_RESP
	} sram_state_e;

	sram_state_e           state;
	word_t                 mem [MEM_WORDS];
	logic                  rd_fire;
	logic                  wr_fire;
	logic                  rd_in_range;
	logic                  wr_in_range;
	logic [WORD_IDX_W-1:0] rd_idx;
	logic [WORD_IDX_W-1:0] wr_idx;

	// ************************************************
	// Handshake
	// ************************************************
	assign arready = (state == S_IDLE);
	// Write address and data are taken together.
	assign awready = (state == S_IDLE) & awvalid & wvalid;
	assign wready  = awready;

	assign rd_fire = arvalid & arready;
	assign wr_fire = awvalid & awready;

	assign rd_in_range = (ar.addr < MEM_BYTES);
	assign wr_in_range = (aw.addr < MEM_BYTES);
	assign rd_idx      = ar.addr[WORD_IDX_W+1:2];
	assign wr_idx      = aw.addr[WORD_IDX_W+1:2];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			rvalid <= rd_fire;    // One-cycle response pulses.
			bvalid <= wr_fire;
			if (rd_fire | wr_fire)
				state <= S_RESP;
			else
				state <= S_IDLE;
		end
	end

	// ************************************************
	// Storage and response data
	// ************************************************
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (wr_fire && wr_in_range) begin
			for (int b = 0; b < 4; b++) begin
				if (w.strb[b])
					mem[wr_idx][8*b +: 8] <= w.data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			r.data <= rd_in_range ? mem[rd_idx] : '0;
			r.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_fire)
			bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
	end

endmodule

`default_nettype wire

/* lsu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_control import lsu_pkg::*; (
	input  wire        clock,
	input  wire        rst_n,

	input  lsu_req_t   req,
	input  wire        lsu_valid,
	output logic       lsu_ready,

	output wb_t        wb,
	output logic       wb_valid,

	output axi_addr_t  ar,
	output logic       arvalid,
	input  wire        arready,
	input  axi_r_t     r,
	input  wire        rvalid,

	output axi_addr_t  aw,
	output logic       awvalid,
	input  wire        awready,
	input  axi_w_t     w_data_in,
	output axi_w_t     w,
	output logic       wvalid,
	input  wire        wready,
	input  resp_t      bresp,
	input  wire        bvalid,

	output funct3_t    funct3,
	output logic [1:0] offset,
	input  word_t      load_val
);

	lsu_state_e state;
	lsu_state_e state_next;
	word_t      addr_q;
	funct3_t    funct3_q;
	logic       accept;

	assign accept = lsu_valid & lsu_ready;

	// ************************************************
	// Control FSM
	// ************************************************
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (lsu_valid) begin
					if (req.ren)
						state_next = READ_ADDR;
					else if (req.wen)
						state_next = WRITE;
					else
						state_next = DONE;    // Register-only op.
				end
			end
			READ_ADDR:  if (arready) state_next = READ_DATA;
			READ_DATA:  if (rvalid) state_next = DONE;
			WRITE:      if (awready & wready) state_next = WRITE_RESP;
			WRITE_RESP: if (bvalid) state_next = DONE;
			DONE:       state_next = IDLE;
			default:    state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	assign lsu_ready = (state == IDLE);
	assign wb_valid  = (state == DONE);
	assign arvalid   = (state == READ_ADDR);
	assign awvalid   = (state == WRITE);
	assign wvalid    = (state == WRITE);

	// While idle the aligners see the incoming request so that w can be captured at accept.
	assign funct3 = (state == IDLE) ? req.funct3 : funct3_q;
	assign offset = (state == IDLE) ? req.exu_val[1:0] : addr_q[1:0];

	assign ar.addr = addr_q;
	assign ar.size = {1'b0, funct3_q[1:0]};    // 1, 2 or 4 bytes.
	assign aw.addr = addr_q;
	assign aw.size = {1'b0, funct3_q[1:0]};

	// ************************************************
	// Request capture and write-back
	// ************************************************
	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q     <= req.exu_val;
			funct3_q   <= req.funct3;
			w          <= w_data_in;
			wb.val     <= req.exu_val;    // Pass-through value.
			wb.rd      <= req.rd;
			wb.reg_wen <= req.reg_wen;
			wb.err     <= 1'b0;
		end else if (state == READ_DATA && rvalid) begin
			wb.val <= (r.resp == RESP_OKAY) ? load_val : '0;
			wb.err <= (r.resp != RESP_OKAY);
		end else if (state == WRITE_RESP && bvalid) begin
			wb.err <= (bresp != RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top import lsu_pkg::*; (
	input  wire       clock,
	input  wire       rst_n,
	input  lsu_req_t  req,
	input  wire       lsu_valid,
	output logic      lsu_ready,
	output wb_t       wb,
	output logic      wb_valid
);

	axi_addr_t  ar;
	axi_addr_t  aw;
	axi_r_t     r;
	axi_w_t     w;
	axi_w_t     w_data;
	resp_t      bresp;
	logic       arvalid;
	logic       arready;
	logic       rvalid;
	logic       awvalid;
	logic       awready;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	funct3_t    funct3;
	logic [1:0] offset;
	word_t      load_val;

	lsu_control control0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.req       (req),
		.lsu_valid (lsu_valid),
		.lsu_ready (lsu_ready),
		.wb        (wb),
		.wb_valid  (wb_valid),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.r         (r),
		.rvalid    (rvalid),
		.aw        (aw),
		.awvalid   (awvalid),
		.awready   (awready),
		.w_data_in (w_data),
		.w         (w),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.funct3    (funct3),
		.offset    (offset),
		.load_val  (load_val)
	);

	store_align store_align0 (
		.funct3     (funct3),
		.offset     (offset),
		.store_data (req.store_data),    // Live request, captured at accept.
		.w_data     (w_data)
	);

	load_extend load_extend0 (
		.funct3   (funct3),
		.offset   (offset),
		.rdata    (r.data),
		.load_val (load_val)
	);

	data_sram sram0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid)
	);

endmodule

`default_nettype wire

/* tb_lsu_checks.svh */
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

// ************************************************
// Compare tasks
// ************************************************
task automatic check_wb(input wb_t got, input wb_t exp, input string name);
	if (got !== exp) begin
		$display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
		stop_failed();
	end
endtask

task automatic check_ready(input logic got, input logic exp, input string name);
	if (got !== exp) begin
		$display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
		stop_failed();
	end
endtask

// ************************************************
// Memory model helpers
// ************************************************
function automatic word_t merge_store(word_t old, funct3_t f3, logic [1:0] off, word_t data);
	word_t merged;
	int    nbytes;
	merged = old;
	nbytes = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
	for (int b = 0; b < nbytes; b++)
		merged[8*(off+b) +: 8] = data[8*b +: 8];    // Low store bytes land from the offset lane up.
	return merged;
endfunction

function automatic word_t extract_load(word_t mem_word, funct3_t f3, logic [1:0] off);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = mem_word[8*off +: 8];
	hi = (off < 3) ? mem_word[8*(off+1) +: 8] : 8'h00;
	case (f3)
		F3_B:    return {{24{lo[7]}}, lo};
		F3_H:    return {{16{hi[7]}}, hi, lo};
		F3_W:    return mem_word;
		F3_BU:   return {24'd0, lo};
		F3_HU:   return {16'd0, hi, lo};
		default: return '0;
	endcase
endfunction

`endif

/* tb_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

	localparam int unsigned SEED = 32'h27a2_59a4;
	localparam int N_RANDOM      = 2000;
	localparam int N_DIRECTED    = 46;
	localparam int N_OPS         = N_DIRECTED + N_RANDOM;
	localparam int LIMIT_CYCLES  = N_OPS * 6 + 100;
	localparam int MAX_WAIT      = 8;

	logic     clock;
	logic     rst_n;
	lsu_req_t req;
	logic     lsu_valid;
	logic     lsu_ready;
	wb_t      wb;
	logic     wb_valid;
	word_t    ref_mem [MEM_WORDS];

	lsu_top dut0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.req       (req),
		.lsu_valid (lsu_valid),
		.lsu_ready (lsu_ready),
		.wb        (wb),
		.wb_valid  (wb_valid)
	);

	task automatic stop_failed();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "tb_lsu_checks.svh"

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clock);
		$display("Watchdog timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		stop_failed();
	end

	function automatic lsu_req_t build_req(logic ren, logic wen, funct3_t f3, word_t addr,
			word_t data);
		lsu_req_t op;
		op.exu_val    = addr;
		op.store_data = data;
		op.funct3     = f3;
		op.rd         = reg_idx_t'($urandom);
		op.ren        = ren;
		op.wen        = wen;
		op.reg_wen    = 1'($urandom_range(0, 1));
		return op;
	endfunction

	function automatic lsu_req_t random_op();
		int unsigned kind;
		int unsigned sel;
		funct3_t     f3;
		word_t       addr;
		kind = $urandom_range(0, 2);    // Register-only, load, store.
		sel  = (kind == 2) ? $urandom_range(0, 2) : $urandom_range(0, 4);
		f3   = funct3_t'((sel < 3) ? sel : sel + 1);
		addr = {22'd0, 8'($urandom_range(0, 63)), 2'd0};
		if ($urandom_range(0, 9) == 0)
			addr = ($urandom | 32'h0000_0400) & 32'hffff_fffc;    // Out of range.
		case (f3[1:0])
			2'd0:    addr[1:0] = 2'($urandom_range(0, 3));
			2'd1:    addr[1:0] = 2'($urandom_range(0, 2));
			default: addr[1:0] = 2'd0;
		endcase
		if (kind == 0)
			addr = $urandom;
		return build_req(kind == 1, kind == 2, f3, addr, $urandom);
	endfunction

	// ************************************************
	// One request through accept and write-back
	// ************************************************
	task automatic run_op(input lsu_req_t op, input int gap);
		wb_t        exp;
		int         lat_exp;
		int         lat;
		logic       oob;
		logic [7:0] idx;
		oob         = (op.exu_val >= MEM_BYTES);
		idx         = op.exu_val[9:2];
		exp.val     = op.exu_val;
		exp.rd      = op.rd;
		exp.reg_wen = op.reg_wen;
		exp.err     = 1'b0;
		lat_exp     = (op.ren | op.wen) ? 3 : 1;
		if (op.ren) begin
			exp.err = oob;
			exp.val = oob ? '0 : extract_load(ref_mem[idx], op.funct3, op.exu_val[1:0]);
		end else if (op.wen) begin
			exp.err = oob;
			if (!oob)
				ref_mem[idx] = merge_store(ref_mem[idx], op.funct3, op.exu_val[1:0],
						op.store_data);
		end
		repeat (gap) begin
			@(posedge clock);
			req <= random_op();    // Noise on req while valid is low.
			@(negedge clock);
			check_ready(lsu_ready, 1'b1, "lsu_ready while idle");
		end
		@(posedge clock);
		req       <= op;
		lsu_valid <= 1'b1;
		@(negedge clock);
		check_ready(lsu_ready, 1'b1, "lsu_ready before accept");
		@(posedge clock);
		lsu_valid <= 1'b0;
		req       <= random_op();
		lat = 0;
		do begin
			@(negedge clock);
			lat++;
			check_ready(lsu_ready, 1'b0, "lsu_ready while busy");
		end while (!wb_valid && lat < MAX_WAIT);
		if (lat != lat_exp) begin
			$display("Write-back came %0d cycles after accept instead of %0d", lat, lat_exp);
			stop_failed();
		end
		check_wb(wb, exp, "wb");
		@(negedge clock);
		check_ready(lsu_ready, 1'b1, "lsu_ready after write-back");
		check_ready(wb_valid, 1'b0, "wb_valid after write-back");
		check_wb(wb, exp, "wb held");
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n     = 1'b0;
		lsu_valid = 1'b0;
		req       = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = '0;
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_ready(lsu_ready, 1'b1, "lsu_ready after reset");
		check_ready(wb_valid, 1'b0, "wb_valid after reset");
		for (int i = 0; i < 8; i++)
			run_op(build_req(1'b0, 1'b0, funct3_t'($urandom), $urandom, $urandom), 0);
		// Each width at each offset inside one word is read back as a whole word.
		for (int wd = 0; wd < 3; wd++) begin
			for (int off = 0; off < ((wd == 2) ? 1 : 4 - wd); off++) begin
				run_op(build_req(1'b0, 1'b1, funct3_t'(wd), 32'h40 + 4*wd + off, $urandom), 0);
				run_op(build_req(1'b1, 1'b0, F3_W, 32'h40 + 4*wd, '0), 0);
			end
		end
		run_op(build_req(1'b0, 1'b1, F3_W, 32'h80, 32'h807f_ff01), 0);    // Mixed sign bytes.
		for (int off = 0; off < 4; off++) begin
			run_op(build_req(1'b1, 1'b0, F3_B, 32'h80 + off, '0), 0);
			run_op(build_req(1'b1, 1'b0, F3_BU, 32'h80 + off, '0), 0);
			if (off < 3) begin
				run_op(build_req(1'b1, 1'b0, F3_H, 32'h80 + off, '0), 0);
				run_op(build_req(1'b1, 1'b0, F3_HU, 32'h80 + off, '0), 0);
			end
		end
		// Out-of-range stores alias word 2 in the low address bits.
		run_op(build_req(1'b0, 1'b1, F3_W, 32'h8, 32'h1234_5678), 0);
		run_op(build_req(1'b0, 1'b1, F3_W, 32'h408, 32'hdead_beef), 0);
		run_op(build_req(1'b1, 1'b0, F3_W, 32'h8, '0), 0);
		run_op(build_req(1'b0, 1'b1, F3_H, 32'hffff_fc0a, 32'h0000_a5a5), 0);
		run_op(build_req(1'b1, 1'b0, F3_W, 32'h8, '0), 0);
		run_op(build_req(1'b1, 1'b0, F3_BU, 32'h400, '0), 0);
		run_op(build_req(1'b1, 1'b0, F3_W, 32'h8000_0008, '0), 0);
		for (int i = 0; i < N_RANDOM; i++)
			run_op(random_op(), ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
lsu_pkg.sv
store_align.sv
load_extend.sv
data_sram.sv
lsu_control.sv
lsu_top.sv
tb_lsu.sv
